//--- common/figure_defs.svh
// Figure movement constants
// Screen and level geometry, sprite size, probe offsets,
// jump profile thresholds and moving platform size
`ifndef FIGURE_DEFS_SVH
`define FIGURE_DEFS_SVH

// --------------------
`define SCREEN_W      640
`define SCREEN_H      480
`define TILE_SIZE     4
`define FLOOR_TOP     400
`define BORDER        16
`define LEDGE_X0      200  // Ledge spans X0 up to X1, X1 excluded
`define LEDGE_X1      320
`define LEDGE_TOP     240  // Rows TOP up to BOTTOM, BOTTOM excluded
`define LEDGE_BOTTOM  252

// --------------------
`define FIG_W         20
`define FIG_H         34
`define START_X       30
`define START_Y       361

// Probe offsets from the sprite's top-left corner
// Side and foot probes sit one pixel further out to cover the state latency
`define PROBE_HEAD_DY    (-2)
`define PROBE_MID_DY     16
`define PROBE_SHIN_DY    (`FIG_H - 2)
`define PROBE_FOOT_DY    (`FIG_H + 1)
`define PROBE_HEAD_L_DX  2
`define PROBE_HEAD_C_DX  (`FIG_W / 2)
`define PROBE_HEAD_R_DX  (`FIG_W - 3)
`define PROBE_SIDE_L_DX  (-2)
`define PROBE_SIDE_R_DX  (`FIG_W + 1)
`define PROBE_SHIN_L_DX  (-1)
`define PROBE_SHIN_R_DX  (`FIG_W)
`define PROBE_FOOT_L_DX  4
`define PROBE_FOOT_R_DX  (`FIG_W - 5)

// --------------------
`define JUMP_BUDGET   44
`define JUMP_FAST     25
`define ARC_FAST      23
`define ARC_FLAT      12
`define PLATFORM_W    64
`define PLATFORM_H    8

`endif

//--- common/figure_pkg.sv
// Figure movement types
// Screen coordinate, movement FSM states and the status code
// seen by the display side
`default_nettype none

package figure_pkg;

	typedef logic [9:0] coord_t;  // Wraps modulo 1024

	typedef enum logic [3:0] {
		still,
		walk_left,
		walk_right,
		jump,
		fall,
		jump_right,
		jump_left,
		fall_right,
		fall_left,
		frozen
	} move_state_e;

	// Encoding is fixed, the sprite selector decodes it
	typedef enum logic [3:0] {
		idle        = 4'd0,
		face_left   = 4'd1,
		face_right  = 4'd2,
		jumping     = 4'd3,
		falling     = 4'd4,
		arc_right   = 4'd5,
		arc_left    = 4'd6,
		drift_right = 4'd7,
		drift_left  = 4'd8
	} figure_status_e;

endpackage

`default_nettype wire

//--- source/level_map.sv
// Level map
// Decides whether a screen point is inside a wall tile. The level is
// two border bands, the floor band and one ledge, all on the tile grid
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module level_map (
	input  figure_pkg::coord_t px,
	input  figure_pkg::coord_t py,
	output logic               wall
);
	import figure_pkg::*;

	coord_t tile_x;
	coord_t tile_y;
	logic   in_border;
	logic   in_floor;
	logic   in_ledge;

	assign tile_x = px / coord_t'(`TILE_SIZE);
	assign tile_y = py / coord_t'(`TILE_SIZE);

	assign in_border = (tile_x < coord_t'(`BORDER / `TILE_SIZE)) ||
		(tile_x >= coord_t'((`SCREEN_W - `BORDER) / `TILE_SIZE));

	assign in_floor = tile_y >= coord_t'(`FLOOR_TOP / `TILE_SIZE);

	assign in_ledge = (tile_x >= coord_t'(`LEDGE_X0 / `TILE_SIZE)) &&
		(tile_x < coord_t'(`LEDGE_X1 / `TILE_SIZE)) &&
		(tile_y >= coord_t'(`LEDGE_TOP / `TILE_SIZE)) &&
		(tile_y < coord_t'(`LEDGE_BOTTOM / `TILE_SIZE));

	assign wall = in_border || in_floor || in_ledge;

endmodule

`default_nettype wire

//--- sense/platform_hit.sv
// Platform hit test
// High when a point lies inside the moving platform rectangle
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module platform_hit (
	input  figure_pkg::coord_t px,
	input  figure_pkg::coord_t py,
	input  figure_pkg::coord_t plat_x,
	input  figure_pkg::coord_t plat_y,
	output logic               hit
);

	logic [10:0] x_end;  // One bit wider, platform may sit at the screen edge
	logic [10:0] y_end;

	assign x_end = {1'b0, plat_x} + 11'(`PLATFORM_W);
	assign y_end = {1'b0, plat_y} + 11'(`PLATFORM_H);

	assign hit = (px >= plat_x) && ({1'b0, px} < x_end) &&
		(py >= plat_y) && ({1'b0, py} < y_end);

endmodule

`default_nettype wire

//--- sense/contact_sense.sv
// Contact sensing
// Places nine probe points around the sprite, tests each one against
// the level map and the moving platform, and groups the hits into
// blocking flags per direction, step flags and platform support
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module contact_sense (
	input  figure_pkg::coord_t fig_x,
	input  figure_pkg::coord_t fig_y,
	input  figure_pkg::coord_t plat_x,
	input  figure_pkg::coord_t plat_y,
	output logic               block_up,
	output logic               block_down,
	output logic               block_left,
	output logic               block_right,
	output logic               block_up_left,
	output logic               block_up_right,
	output logic               block_down_left,
	output logic               block_down_right,
	output logic               step_left,
	output logic               step_right,
	output logic               on_platform
);
	import figure_pkg::*;

	localparam int NUM_PROBES = 9;
	localparam int HEAD_L = 0;
	localparam int HEAD_C = 1;
	localparam int HEAD_R = 2;
	localparam int MID_L  = 3;
	localparam int MID_R  = 4;
	localparam int SHIN_L = 5;
	localparam int SHIN_R = 6;
	localparam int FOOT_L = 7;
	localparam int FOOT_R = 8;

	coord_t probe_x [NUM_PROBES];
	coord_t probe_y [NUM_PROBES];
	logic   wall_hit [NUM_PROBES];
	logic   plat_hit [NUM_PROBES];
	logic   solid [NUM_PROBES];

	// Probe placement --------------------
	assign probe_x[HEAD_L] = coord_t'(fig_x + `PROBE_HEAD_L_DX);
	assign probe_y[HEAD_L] = coord_t'(fig_y + `PROBE_HEAD_DY);
	assign probe_x[HEAD_C] = coord_t'(fig_x + `PROBE_HEAD_C_DX);
	assign probe_y[HEAD_C] = coord_t'(fig_y + `PROBE_HEAD_DY);
	assign probe_x[HEAD_R] = coord_t'(fig_x + `PROBE_HEAD_R_DX);
	assign probe_y[HEAD_R] = coord_t'(fig_y + `PROBE_HEAD_DY);
	assign probe_x[MID_L]  = coord_t'(fig_x + `PROBE_SIDE_L_DX);
	assign probe_y[MID_L]  = coord_t'(fig_y + `PROBE_MID_DY);
	assign probe_x[MID_R]  = coord_t'(fig_x + `PROBE_SIDE_R_DX);
	assign probe_y[MID_R]  = coord_t'(fig_y + `PROBE_MID_DY);
	assign probe_x[SHIN_L] = coord_t'(fig_x + `PROBE_SHIN_L_DX);
	assign probe_y[SHIN_L] = coord_t'(fig_y + `PROBE_SHIN_DY);
	assign probe_x[SHIN_R] = coord_t'(fig_x + `PROBE_SHIN_R_DX);
	assign probe_y[SHIN_R] = coord_t'(fig_y + `PROBE_SHIN_DY);
	assign probe_x[FOOT_L] = coord_t'(fig_x + `PROBE_FOOT_L_DX);
	assign probe_y[FOOT_L] = coord_t'(fig_y + `PROBE_FOOT_DY);
	assign probe_x[FOOT_R] = coord_t'(fig_x + `PROBE_FOOT_R_DX);
	assign probe_y[FOOT_R] = coord_t'(fig_y + `PROBE_FOOT_DY);

	// One wall and one platform test per probe
	for (genvar i = 0; i < NUM_PROBES; i++) begin : g_probe
		level_map level_map_i (
			.px   (probe_x[i]),
			.py   (probe_y[i]),
			.wall (wall_hit[i])
		);

		platform_hit platform_hit_i (
			.px     (probe_x[i]),
			.py     (probe_y[i]),
			.plat_x (plat_x),
			.plat_y (plat_y),
			.hit    (plat_hit[i])
		);

		assign solid[i] = wall_hit[i] || plat_hit[i];
	end

	// Direction grouping --------------------
	assign block_up    = solid[HEAD_L] || solid[HEAD_C] || solid[HEAD_R];
	assign block_down  = solid[FOOT_L] || solid[FOOT_R];
	assign block_left  = solid[HEAD_L] || solid[MID_L];
	assign block_right = solid[HEAD_R] || solid[MID_R];

	assign block_up_left    = block_up || solid[MID_L];
	assign block_up_right   = block_up || solid[MID_R];
	assign block_down_left  = block_down || solid[MID_L];
	assign block_down_right = block_down || solid[MID_R];

	assign step_left   = solid[SHIN_L];  // Low obstacle, climb instead of walk
	assign step_right  = solid[SHIN_R];
	assign on_platform = plat_hit[FOOT_L] || plat_hit[FOOT_R];

endmodule

`default_nettype wire

//--- motion/move_fsm.sv
// Movement FSM
// Picks walk, jump, fall or freeze from the keys and the contact flags,
// once per frame. Also counts down the jump budget, which shapes
// the rising profile and ends the jump
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module move_fsm (
	input  logic                    reset,
	input  logic                    frame_clk,
	input  logic                    move_left,
	input  logic                    move_right,
	input  logic                    move_up,
	input  logic                    round_over,
	input  logic                    block_up,
	input  logic                    block_down,
	input  logic                    block_left,
	input  logic                    block_right,
	input  logic                    block_up_left,
	input  logic                    block_up_right,
	input  logic                    block_down_left,
	input  logic                    block_down_right,
	output figure_pkg::move_state_e state,
	output figure_pkg::coord_t      jump_budget
);
	import figure_pkg::*;

	move_state_e next_state;
	coord_t      next_budget;
	coord_t      budget_dec;
	logic        budget_done;
	logic        want_left;
	logic        want_right;
	logic        want_jump;
	logic        want_jump_left;
	logic        want_jump_right;

	assign budget_dec  = jump_budget - 10'd1;
	assign budget_done = budget_dec == '0;  // Last rising step this frame

	// Key decode, left wins over right
	assign want_left       = move_left && !move_up && !block_left;
	assign want_right      = move_right && !move_up && !block_right;
	assign want_jump       = move_up && !move_left && !move_right && !block_up;
	assign want_jump_right = move_up && move_right && !block_up_right;
	assign want_jump_left  = move_up && move_left && !block_up_left;

	// Next state --------------------
	always_comb begin
		next_state = state;
		if (round_over || state == frozen) begin
			next_state = frozen;
		end else begin
			case (state)
				jump: begin
					if (budget_done || block_up)
						next_state = fall;
				end
				jump_right: begin
					if (budget_done)
						next_state = fall_right;
					else if (block_up_right)
						next_state = fall;
				end
				jump_left: begin
					if (budget_done)
						next_state = fall_left;
					else if (block_up_left)
						next_state = fall;
				end
				fall: begin
					if (block_down)
						next_state = still;
				end
				fall_right: begin
					if (!block_down_right)
						next_state = fall_right;
					else if (!block_down)
						next_state = fall;
					else
						next_state = still;
				end
				fall_left: begin
					if (!block_down_left)
						next_state = fall_left;
					else if (!block_down)
						next_state = fall;
					else
						next_state = still;
				end
				default: begin  // Standing or walking
					if (!block_down) begin
						if (state == walk_left)
							next_state = fall_left;
						else if (state == walk_right)
							next_state = fall_right;
						else
							next_state = fall;
					end else if (want_left) begin
						next_state = walk_left;
					end else if (want_right) begin
						next_state = walk_right;
					end else if (want_jump) begin
						next_state = jump;
					end else if (want_jump_right) begin
						next_state = jump_right;
					end else if (want_jump_left) begin
						next_state = jump_left;
					end else begin
						next_state = still;
					end
				end
			endcase
		end
	end

	always_comb begin
		case (state)
			jump, jump_left, jump_right: next_budget = budget_dec;
			fall, fall_left, fall_right: next_budget = coord_t'(`JUMP_BUDGET);
			default:                     next_budget = jump_budget;
		endcase
	end

	// frame_clk is the asynchronous reset here
	always_ff @(posedge reset or posedge frame_clk) begin
		if (frame_clk) begin
			state       <= still;
			jump_budget <= coord_t'(`JUMP_BUDGET);
		end else begin
			state       <= next_state;
			jump_budget <= next_budget;
		end
	end

endmodule

`default_nettype wire

//--- motion/position_update.sv
// Position integrator
// Turns the current movement state into a per-frame step in x and y,
// adds the lift of a rising platform, and registers the position
// together with the status code
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module position_update (
	input  logic                       reset,
	input  logic                       frame_clk,
	input  figure_pkg::move_state_e    state,
	input  figure_pkg::coord_t         jump_budget,
	input  logic                       step_left,
	input  logic                       step_right,
	input  logic                       on_platform,
	input  logic                       plat_rising,
	input  logic                       move_left,
	input  logic                       move_right,
	output figure_pkg::coord_t         fig_x,
	output figure_pkg::coord_t         fig_y,
	output figure_pkg::figure_status_e status
);
	import figure_pkg::*;

	coord_t         dx;  // Two's complement step
	coord_t         dy;
	coord_t         rise_dy;
	coord_t         arc_dy;
	figure_status_e next_status;

	assign rise_dy = (jump_budget >= `JUMP_FAST) ? -10'sd2 : -10'sd1;
	assign arc_dy  = (jump_budget >= `ARC_FAST) ? -10'sd2 :
		(jump_budget <= `ARC_FLAT) ? 10'd0 : -10'sd1;

	always_comb begin
		dx          = '0;
		dy          = '0;
		next_status = status;
		case (state)
			still: begin
				if (move_left)
					next_status = face_left;
				else if (move_right)
					next_status = face_right;
				else
					next_status = idle;
			end
			walk_left: begin
				if (step_left)
					dy = -10'sd1;  // Climb the step
				else
					dx = -10'sd1;
				next_status = face_left;
			end
			walk_right: begin
				if (step_right)
					dy = -10'sd1;
				else
					dx = 10'd1;
				next_status = face_right;
			end
			jump: begin
				dy          = rise_dy;
				next_status = jumping;
			end
			jump_right: begin
				dx          = 10'd1;
				dy          = arc_dy;
				next_status = arc_right;
			end
			jump_left: begin
				dx          = -10'sd1;
				dy          = arc_dy;
				next_status = arc_left;
			end
			fall: begin
				dy          = 10'd1;
				next_status = falling;
			end
			fall_right: begin
				dx          = 10'd1;
				dy          = 10'd1;
				next_status = drift_right;
			end
			fall_left: begin
				dx          = -10'sd1;
				dy          = 10'd1;
				next_status = drift_left;
			end
			default: ;  // Frozen keeps everything
		endcase
		if (plat_rising && on_platform && state != frozen)
			dy = dy - 10'd1;  // Carried by the platform
	end

	always_ff @(posedge reset or posedge frame_clk) begin
		if (frame_clk) begin
			fig_x  <= coord_t'(`START_X);
			fig_y  <= coord_t'(`START_Y);
			status <= idle;
		end else begin
			fig_x  <= fig_x + dx;
			fig_y  <= fig_y + dy;
			status <= next_status;
		end
	end

endmodule

`default_nettype wire

//--- source/figure_move.sv
// Figure movement top level
// Contact sensing feeds the movement FSM, the FSM drives the position
// integrator, and the registered position closes the loop
`timescale 1ns/1ns
`default_nettype none

module figure_move (
	input  logic                       reset,
	input  logic                       frame_clk,
	input  logic                       move_left,
	input  logic                       move_right,
	input  logic                       move_up,
	input  logic                       round_over,
	input  logic                       plat_rising,
	input  figure_pkg::coord_t         plat_x,
	input  figure_pkg::coord_t         plat_y,
	output figure_pkg::coord_t         fig_x,
	output figure_pkg::coord_t         fig_y,
	output figure_pkg::figure_status_e status
);
	import figure_pkg::*;

	logic        block_up;
	logic        block_down;
	logic        block_left;
	logic        block_right;
	logic        block_up_left;
	logic        block_up_right;
	logic        block_down_left;
	logic        block_down_right;
	logic        step_left;
	logic        step_right;
	logic        on_platform;
	move_state_e state;
	coord_t      jump_budget;

	contact_sense contact_sense_i (
		.fig_x            (fig_x),
		.fig_y            (fig_y),
		.plat_x           (plat_x),
		.plat_y           (plat_y),
		.block_up         (block_up),
		.block_down       (block_down),
		.block_left       (block_left),
		.block_right      (block_right),
		.block_up_left    (block_up_left),
		.block_up_right   (block_up_right),
		.block_down_left  (block_down_left),
		.block_down_right (block_down_right),
		.step_left        (step_left),
		.step_right       (step_right),
		.on_platform      (on_platform)
	);

	move_fsm move_fsm_i (
		.reset            (reset),
		.frame_clk        (frame_clk),
		.move_left        (move_left),
		.move_right       (move_right),
		.move_up          (move_up),
		.round_over       (round_over),
		.block_up         (block_up),
		.block_down       (block_down),
		.block_left       (block_left),
		.block_right      (block_right),
		.block_up_left    (block_up_left),
		.block_up_right   (block_up_right),
		.block_down_left  (block_down_left),
		.block_down_right (block_down_right),
		.state            (state),
		.jump_budget      (jump_budget)
	);

	position_update position_update_i (
		.reset       (reset),
		.frame_clk   (frame_clk),
		.state       (state),
		.jump_budget (jump_budget),
		.step_left   (step_left),
		.step_right  (step_right),
		.on_platform (on_platform),
		.plat_rising (plat_rising),
		.move_left   (move_left),
		.move_right  (move_right),
		.fig_x       (fig_x),
		.fig_y       (fig_y),
		.status      (status)
	);

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
// Frame clock and reset source
// 10 ns frame clock on reset, frame_clk held high for the first
// three rising edges
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic reset,
	output logic frame_clk
);

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 3;

	initial begin
		reset = 1'b0;
		forever #HALF_PERIOD reset = ~reset;
	end

	initial begin
		frame_clk = 1'b1;
		repeat (RESET_CYCLES) @(posedge reset);
		#1 frame_clk = 1'b0;  // Release just after the edge
	end

endmodule

`default_nettype wire

//--- testbench/figure_move_tb.sv
// Figure movement testbench
// Directed tests for reset, falling, walking, jumping, the rising
// platform and the end-of-round freeze
`timescale 1ns/1ns
`default_nettype none
`include "figure_defs.svh"

module figure_move_tb;
	import figure_pkg::*;

	localparam int REST_Y        = `FLOOR_TOP - `FIG_H;
	localparam int FAST_STEPS    = `JUMP_BUDGET - `JUMP_FAST + 1;  // Steps of 2 pixels
	localparam int JUMP_RISE     = 2 * FAST_STEPS + (`JUMP_BUDGET - FAST_STEPS);
	localparam int PARK_POS      = 900;  // Platform out of sight
	localparam int LIFT_STEPS    = 30;
	localparam int WALK_FRAMES   = 20;
	localparam int FREEZE_FRAMES = 50;
	localparam int RESET_LIMIT   = 10;
	localparam int WAIT_LIMIT    = 10;
	localparam int FALL_LIMIT    = 200;
	localparam int WALL_LIMIT    = 200;
	localparam int JUMP_LIMIT    = 300;

	logic           reset;
	logic           frame_clk;
	logic           move_left;
	logic           move_right;
	logic           move_up;
	logic           round_over;
	logic           plat_rising;
	coord_t         plat_x;
	coord_t         plat_y;
	coord_t         fig_x;
	coord_t         fig_y;
	figure_status_e status;
	string          test_name;

	clock_gen clock_gen_i (
		.reset     (reset),
		.frame_clk (frame_clk)
	);

	figure_move figure_move_i (
		.reset       (reset),
		.frame_clk   (frame_clk),
		.move_left   (move_left),
		.move_right  (move_right),
		.move_up     (move_up),
		.round_over  (round_over),
		.plat_rising (plat_rising),
		.plat_x      (plat_x),
		.plat_y      (plat_y),
		.fig_x       (fig_x),
		.fig_y       (fig_y),
		.status      (status)
	);

	// Helpers --------------------
	task automatic next_frame();
		@(posedge reset);
		#1;
	endtask

	task automatic fail_and_stop();
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first error in %s", test_name);
	endtask

	task automatic report_timeout(input string what, input int limit);
		$display("Timeout in %s: %s did not happen within %0d frames",
			test_name, what, limit);
		fail_and_stop();
	endtask

	task automatic check_coord(input string what, input coord_t expected,
		input coord_t actual);
		if (actual !== expected) begin
			$display("FAILED %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			fail_and_stop();
		end
	endtask

	task automatic check_status(input string what, input figure_status_e expected,
		input figure_status_e actual);
		if (actual !== expected) begin
			$display("FAILED %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			fail_and_stop();
		end
	endtask

	function automatic coord_t rise_step(input int step);
		return (step < FAST_STEPS) ? 10'd2 : 10'd1;
	endfunction

	task automatic park_platform();
		plat_x      = coord_t'(PARK_POS);
		plat_y      = coord_t'(PARK_POS);
		plat_rising = 1'b0;
	endtask

	task automatic fall_to_floor(input int limit);
		coord_t prev_y;
		int     n;
		logic   seen_fall;
		logic   landed;
		seen_fall = 1'b0;
		landed    = 1'b0;
		n         = 0;
		while (!landed && n < limit) begin
			prev_y = fig_y;
			next_frame();
			n++;
			if (status == falling) begin
				seen_fall = 1'b1;
				check_coord("y while falling", prev_y + 10'd1, fig_y);
			end
			landed = seen_fall && fig_y == prev_y;
		end
		if (!landed)
			report_timeout("landing on the floor", limit);
		check_coord("rest y", coord_t'(REST_Y), fig_y);
		check_status("rest status", idle, status);
	endtask

	// Tests --------------------
	task automatic reset_state();
		int n;
		test_name = "reset_state";
		next_frame();
		check_coord("x in reset", coord_t'(`START_X), fig_x);
		check_coord("y in reset", coord_t'(`START_Y), fig_y);
		check_status("status in reset", idle, status);
		n = 0;
		while (frame_clk === 1'b1 && n < RESET_LIMIT) begin
			@(negedge reset);
			n++;
		end
		if (frame_clk === 1'b1)
			report_timeout("reset release", RESET_LIMIT);
		check_coord("x after reset", coord_t'(`START_X), fig_x);
		check_coord("y after reset", coord_t'(`START_Y), fig_y);
		check_status("status after reset", idle, status);
		next_frame();  // Motion lags the state by one frame
		check_coord("x one frame after reset", coord_t'(`START_X), fig_x);
		check_coord("y one frame after reset", coord_t'(`START_Y), fig_y);
		check_status("status one frame after reset", idle, status);
	endtask

	task automatic settle_on_floor();
		test_name = "settle_on_floor";
		fall_to_floor(FALL_LIMIT);
	endtask

	task automatic walk_to_wall();
		coord_t prev_x;
		int     n;
		int     i;
		logic   stopped;
		test_name  = "walk_to_wall";
		move_right = 1'b1;
		n = 0;
		while (status != face_right && n < WAIT_LIMIT) begin
			next_frame();
			n++;
		end
		if (status != face_right)
			report_timeout("facing right", WAIT_LIMIT);
		for (i = 0; i < WALK_FRAMES; i++) begin
			prev_x = fig_x;
			next_frame();
			check_coord("x while walking right", prev_x + 10'd1, fig_x);
			check_coord("y while walking right", coord_t'(REST_Y), fig_y);
			check_status("status while walking right", face_right, status);
		end
		move_right = 1'b0;
		move_left  = 1'b1;
		stopped    = 1'b0;
		n = 0;
		while (!stopped && n < WALL_LIMIT) begin
			prev_x = fig_x;
			next_frame();
			n++;
			stopped = fig_x == prev_x;
		end
		if (!stopped)
			report_timeout("stop at the left wall", WALL_LIMIT);
		check_coord("x at the left wall", coord_t'(`BORDER), fig_x);
		move_left = 1'b0;
	endtask

	task automatic jump_profile();
		coord_t prev_y;
		coord_t min_y;
		int     steps;
		int     n;
		logic   landed;
		test_name = "jump_profile";
		move_up   = 1'b1;
		min_y     = fig_y;
		steps     = 0;
		landed    = 1'b0;
		n = 0;
		while (!landed && n < JUMP_LIMIT) begin
			prev_y = fig_y;
			next_frame();
			n++;
			if (status == jumping) begin
				move_up = 1'b0;  // One jump only
				check_coord("y while rising", prev_y - rise_step(steps), fig_y);
				steps++;
			end else if (status == falling) begin
				check_coord("y while falling", prev_y + 10'd1, fig_y);
			end
			if (fig_y < min_y)
				min_y = fig_y;
			landed = steps > 0 && status == idle && fig_y == prev_y;
		end
		if (!landed)
			report_timeout("landing after the jump", JUMP_LIMIT);
		check_coord("rising frames", coord_t'(`JUMP_BUDGET), coord_t'(steps));
		check_coord("highest y", coord_t'(REST_Y - JUMP_RISE), min_y);
		check_coord("landing y", coord_t'(REST_Y), fig_y);
	endtask

	task automatic platform_lift();
		coord_t start_y;
		int     i;
		test_name   = "platform_lift";
		start_y     = fig_y;
		plat_x      = fig_x;
		plat_y      = fig_y + coord_t'(`FIG_H);  // Top row right under the feet
		plat_rising = 1'b1;
		for (i = 1; i <= LIFT_STEPS; i++) begin
			next_frame();
			check_coord("y while lifted", start_y - coord_t'(i), fig_y);
			check_status("status while lifted", idle, status);
			plat_y = plat_y - 10'd1;
		end
		plat_rising = 1'b0;
		next_frame();
		check_coord("y on the stopped platform", start_y - coord_t'(LIFT_STEPS), fig_y);
		check_coord("feet on the platform top", plat_y, fig_y + coord_t'(`FIG_H));
		park_platform();
		fall_to_floor(FALL_LIMIT);
	endtask

	task automatic round_over_freeze();
		coord_t start_x;
		coord_t held_x;
		coord_t held_y;
		int     n;
		int     i;
		test_name  = "round_over_freeze";
		start_x    = fig_x;
		move_right = 1'b1;
		n = 0;
		while (fig_x == start_x && n < WAIT_LIMIT) begin
			next_frame();
			n++;
		end
		if (fig_x == start_x)
			report_timeout("walking right", WAIT_LIMIT);
		round_over = 1'b1;
		next_frame();  // Walk step still in flight
		held_x = fig_x;
		held_y = fig_y;
		for (i = 0; i < FREEZE_FRAMES; i++) begin
			move_left  = i[0];
			move_right = i[1];
			move_up    = i[2];
			next_frame();
			check_coord("x while frozen", held_x, fig_x);
			check_coord("y while frozen", held_y, fig_y);
		end
		move_left  = 1'b0;
		move_right = 1'b0;
		move_up    = 1'b0;
	endtask

	// Sequence --------------------
	initial begin
		test_name  = "start";
		move_left  = 1'b0;
		move_right = 1'b0;
		move_up    = 1'b0;
		round_over = 1'b0;
		park_platform();
		reset_state();
		settle_on_floor();
		walk_to_wall();
		jump_profile();
		platform_lift();
		round_over_freeze();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/figure_pkg.sv
source/level_map.sv
sense/platform_hit.sv
sense/contact_sense.sv
motion/move_fsm.sv
motion/position_update.sv
source/figure_move.sv
testbench/clock_gen.sv
testbench/figure_move_tb.sv

//--- Bender.yml
package:
  name: figure_move

export_include_dirs:
  - common

sources:
  - files:
      - common/figure_pkg.sv
      - source/level_map.sv
      - sense/platform_hit.sv
      - sense/contact_sense.sv
      - motion/move_fsm.sv
      - motion/position_update.sv
      - source/figure_move.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/figure_move_tb.sv
